//--- list.f
src/wb_pkg.sv
src/mem_load_align.sv
src/csr.sv
src/wb_stage.sv
src/regfile.sv
src/wb_top.sv
sim/wb_top_sva.sv
sim/tb_wb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build tb_wb_top with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_wb_top \
    -Mdir obj_dir -o tb_wb_top -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_wb_top > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$log"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- sim/tb_wb_top.sv
module tb_wb_top;
    import wb_pkg::*;

    localparam int wait_limit = 20;

    logic                  clk;
    logic                  resetn;
    logic                  mem_valid;
    logic [xlen-1:0]       mem_pc;
    logic                  mem_rf_we;
    logic [reg_addr_w-1:0] mem_rf_waddr;
    logic [xlen-1:0]       mem_alu_result;
    logic                  mem_is_load;
    ld_op_t                mem_load_op;
    logic [xlen-1:0]       mem_rdata;
    logic                  mem_res_from_csr;
    logic [csr_num_w-1:0]  mem_csr_num;
    logic                  mem_csr_we;
    logic [xlen-1:0]       mem_csr_wmask;
    logic [xlen-1:0]       mem_csr_wvalue;
    logic                  mem_ertn;
    logic                  mem_ex;
    logic [ecode_w-1:0]    mem_ecode;
    logic [esubcode_w-1:0] mem_esubcode;
    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic                  wb_allowin;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic [xlen-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_we;
    logic [reg_addr_w-1:0] debug_wb_rf_wnum;
    logic [xlen-1:0]       debug_wb_rf_wdata;
    logic                  wb_flush;
    logic [xlen-1:0]       flush_target;

    integer seed = 32'h83b7;
    int     errors;
    int     tests_run;
    int     tests_failed;
    bit     timed_out;
    ld_op_t ops [0:4] = '{ld_w, ld_b, ld_bu, ld_h, ld_hu};

    // reference state
    logic [xlen-1:0] rf_model [0:31];
    logic [xlen-1:0] crmd_m;
    logic [xlen-1:0] prmd_m;
    logic [xlen-1:0] estat_m;
    logic [xlen-1:0] era_m;
    logic [xlen-1:0] eentry_m;
    logic [xlen-1:0] save0_m;

    wb_top wb_top_inst (.*);

    bind wb_top wb_top_sva wb_top_sva_inst (
        .clk            (clk),
        .resetn         (resetn),
        .mem_valid      (mem_valid),
        .mem_rf_we      (mem_rf_we),
        .mem_ex         (mem_ex),
        .mem_ertn       (mem_ertn),
        .wb_allowin     (wb_allowin),
        .wb_flush       (wb_flush),
        .debug_wb_rf_we (debug_wb_rf_we)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_inputs();
        mem_valid        = 1'b0;
        mem_pc           = '0;
        mem_rf_we        = 1'b0;
        mem_rf_waddr     = '0;
        mem_alu_result   = '0;
        mem_is_load      = 1'b0;
        mem_load_op      = ld_w;
        mem_rdata        = '0;
        mem_res_from_csr = 1'b0;
        mem_csr_num      = '0;
        mem_csr_we       = 1'b0;
        mem_csr_wmask    = '0;
        mem_csr_wvalue   = '0;
        mem_ertn         = 1'b0;
        mem_ex           = 1'b0;
        mem_ecode        = '0;
        mem_esubcode     = '0;
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        while (!timed_out && wb_allowin !== 1'b1 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && wb_allowin !== 1'b1) begin
            $display("timeout: write-back stage never accepted an instruction");
            timed_out = 1'b1;
            errors++;
        end
    endtask

    // one instruction, returns in its write-back cycle
    task automatic send();
        wait_allowin();
        if (!timed_out) begin
            mem_valid = 1'b1;
            @(negedge clk);
        end
        clear_inputs();
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    function automatic logic [xlen-1:0] load_expect(ld_op_t op, logic [1:0] off,
                                                    logic [xlen-1:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (op)
            ld_b:    return {{24{b[7]}}, b};
            ld_bu:   return {24'b0, b};
            ld_h:    return {{16{h[15]}}, h};
            ld_hu:   return {16'b0, h};
            default: return word;
        endcase
    endfunction

    function automatic bit aligned_load(ld_op_t op, int off);
        if (op == ld_w) begin
            return off == 0;
        end
        if (op == ld_h || op == ld_hu) begin
            return off % 2 == 0;
        end
        return 1'b1;
    endfunction

    function automatic logic [xlen-1:0] csr_model(logic [csr_num_w-1:0] num);
        case (num)
            csr_crmd:   return crmd_m;
            csr_prmd:   return prmd_m;
            csr_estat:  return estat_m;
            csr_era:    return era_m;
            csr_eentry: return eentry_m;
            csr_save0:  return save0_m;
            default:    return '0;
        endcase
    endfunction

    // csrxchg into r0, the old value shows up on the trace port
    task automatic csr_op(input logic [csr_num_w-1:0] num, input logic we,
                          input logic [xlen-1:0] mask, input logic [xlen-1:0] value);
        logic [xlen-1:0] old;
        logic [xlen-1:0] merged;
        old = csr_model(num);
        merged = (old & ~mask) | (value & mask);
        mem_rf_we        = 1'b1;
        mem_res_from_csr = 1'b1;
        mem_csr_num      = num;
        mem_csr_we       = we;
        mem_csr_wmask    = mask;
        mem_csr_wvalue   = value;
        send();
        check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, old);
        if (we) begin
            case (num)
                csr_crmd:   crmd_m = merged & 32'h0000_000f;
                csr_eentry: eentry_m = merged & 32'hffff_ffc0;
                csr_save0:  save0_m = merged;
                default: begin
                end
            endcase
        end
    endtask

    task automatic reset_state();
        int start;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            check_value("debug_wb_rf_we", xlen'(debug_wb_rf_we), '0);
            check_value("wb_flush", xlen'(wb_flush), '0);
            @(negedge clk);
        end
        csr_op(csr_crmd, 1'b0, '0, '0);
        report_test("reset", start);
    endtask

    task automatic load_alignment();
        int                    start;
        logic [31:0]           r;
        logic [xlen-1:0]       exp;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        start = errors;
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = 0; k < 5; k++) begin
                for (int off = 0; off < 4; off++) begin
                    if (aligned_load(ops[k], off)) begin
                        r = $random(seed);
                        rd = r[4:0] | 5'd1;
                        pc = $random(seed);
                        r = $random(seed);
                        mem_alu_result = {r[31:2], off[1:0]};
                        mem_rdata      = $random(seed);
                        mem_pc         = pc;
                        mem_is_load    = 1'b1;
                        mem_load_op    = ops[k];
                        mem_rf_we      = 1'b1;
                        mem_rf_waddr   = rd;
                        exp = load_expect(ops[k], off[1:0], mem_rdata);
                        send();
                        check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp);
                        check_value("debug_wb_rf_wnum", xlen'(debug_wb_rf_wnum), xlen'(rd));
                        check_value("debug_wb_rf_we", xlen'(debug_wb_rf_we), 32'hf);
                        check_value("debug_wb_pc", debug_wb_pc, pc);
                        rf_model[rd] = exp;
                    end
                end
            end
        end
        report_test("load_align", start);
    endtask

    task automatic register_writes_reads();
        int                    start;
        logic [31:0]           r;
        logic [xlen-1:0]       exp;
        logic [reg_addr_w-1:0] rd;
        start = errors;
        // fill every register first, then random writes with some to r0
        for (int i = 1; i < 56; i++) begin
            r = $random(seed);
            rd = (i < 32) ? i[4:0] : ((i % 6 == 0) ? 5'd0 : r[4:0]);
            exp = $random(seed);
            mem_alu_result = exp;
            mem_rf_we      = 1'b1;
            mem_rf_waddr   = rd;
            send();
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp);
            if (rd != 5'd0) begin
                rf_model[rd] = exp;
            end
        end
        for (int i = 0; i < 32; i++) begin
            rf_raddr1 = i[4:0];
            rf_raddr2 = 5'(31 - i);
            @(negedge clk);
            check_value("rf_rdata1", rf_rdata1, rf_model[i]);
            check_value("rf_rdata2", rf_rdata2, rf_model[31 - i]);
        end
        report_test("regfile", start);
    endtask

    task automatic masked_csr_writes();
        int              start;
        logic [xlen-1:0] mask;
        logic [xlen-1:0] value;
        start = errors;
        for (int i = 0; i < 3; i++) begin
            mask = $random(seed);
            value = $random(seed);
            csr_op(csr_save0, 1'b1, mask, value);
            csr_op(csr_save0, 1'b0, '0, '0);
            mask = $random(seed);
            value = $random(seed);
            csr_op(csr_eentry, 1'b1, mask, value);
            csr_op(csr_eentry, 1'b0, '0, '0);
        end
        report_test("csr_mask", start);
    endtask

    task automatic exception_entry();
        int              start;
        logic [31:0]     r;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
        start = errors;
        // leave plv 3 and ie set so prmd has something to save
        csr_op(csr_crmd, 1'b1, 32'h7, 32'h7);
        pc = $random(seed);
        r = $random(seed);
        target = eentry_m;
        mem_pc         = pc;
        mem_ex         = 1'b1;
        mem_ecode      = r[5:0];
        mem_esubcode   = r[14:6];
        mem_csr_we     = 1'b1;
        mem_csr_num    = csr_save0;
        mem_csr_wmask  = '1;
        mem_csr_wvalue = ~save0_m;
        send();
        check_value("wb_flush", xlen'(wb_flush), 32'h1);
        check_value("flush_target", flush_target, target);
        prmd_m = '0;
        prmd_m[prmd_pplv_lsb +: 2] = crmd_m[crmd_plv_lsb +: 2];
        prmd_m[prmd_pie_bit] = crmd_m[crmd_ie_bit];
        crmd_m[crmd_plv_lsb +: 2] = 2'b00;
        crmd_m[crmd_ie_bit] = 1'b0;
        era_m = pc;
        estat_m[estat_ecode_lsb +: ecode_w] = r[5:0];
        estat_m[estat_esubcode_lsb +: esubcode_w] = r[14:6];
        @(negedge clk);
        check_value("wb_flush", xlen'(wb_flush), '0);
        csr_op(csr_save0, 1'b0, '0, '0);
        csr_op(csr_era, 1'b0, '0, '0);
        csr_op(csr_estat, 1'b0, '0, '0);
        csr_op(csr_prmd, 1'b0, '0, '0);
        csr_op(csr_crmd, 1'b0, '0, '0);
        report_test("exception", start);
    endtask

    task automatic exception_return();
        int              start;
        logic [xlen-1:0] target;
        start = errors;
        target = era_m;
        mem_pc   = $random(seed);
        mem_ertn = 1'b1;
        send();
        check_value("wb_flush", xlen'(wb_flush), 32'h1);
        check_value("flush_target", flush_target, target);
        crmd_m[crmd_plv_lsb +: 2] = prmd_m[prmd_pplv_lsb +: 2];
        crmd_m[crmd_ie_bit] = prmd_m[prmd_pie_bit];
        @(negedge clk);
        check_value("wb_flush", xlen'(wb_flush), '0);
        csr_op(csr_crmd, 1'b0, '0, '0);
        report_test("ertn", start);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        rf_raddr1 = '0;
        rf_raddr2 = '0;
        clear_inputs();
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        crmd_m = '0;
        crmd_m[crmd_da_bit] = 1'b1;
        prmd_m = '0;
        estat_m = '0;
        era_m = '0;
        eentry_m = '0;
        save0_m = '0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;

        reset_state();
        load_alignment();
        register_writes_reads();
        masked_csr_writes();
        exception_entry();
        exception_return();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/wb_top_sva.sv
module wb_top_sva (
    input logic       clk,
    input logic       resetn,
    input logic       mem_valid,
    input logic       mem_rf_we,
    input logic       mem_ex,
    input logic       mem_ertn,
    input logic       wb_allowin,
    input logic       wb_flush,
    input logic [3:0] debug_wb_rf_we
);

    // stage is empty in the cycle after a reset edge
    a_reset_quiet: assert property (@(posedge clk)
        !resetn |=> (debug_wb_rf_we == 4'h0 && !wb_flush))
        else $error("register write or flush in the cycle after reset");

    // one pulse per flushing instruction
    a_flush_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_flush && !(mem_valid && (mem_ex || mem_ertn)) |=> !wb_flush)
        else $error("wb_flush stayed high for more than one cycle");

    a_flush_follows: assert property (@(posedge clk) disable iff (!resetn)
        mem_valid && wb_allowin && (mem_ex || mem_ertn) |=> wb_flush)
        else $error("accepted exception or ertn did not raise wb_flush");

    // trace strobe is the accepted write enable copied to all bytes
    a_we_strobe: assert property (@(posedge clk) disable iff (!resetn)
        1'b1 |=> debug_wb_rf_we == {4{$past(mem_valid && mem_rf_we)}})
        else $error("debug_wb_rf_we does not follow the accepted write enable");

    a_allowin: assert property (@(posedge clk) disable iff (!resetn)
        wb_allowin)
        else $error("wb_allowin dropped, the stage should never stall");

endmodule

//--- src/csr.sv
module csr (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [wb_pkg::csr_num_w-1:0]  csr_num,
    input  logic                          csr_we,
    input  logic [wb_pkg::xlen-1:0]       csr_wmask,
    input  logic [wb_pkg::xlen-1:0]       csr_wvalue,
    input  logic                          ertn_flush,
    input  logic                          wb_ex,
    input  logic [wb_pkg::ecode_w-1:0]    wb_ecode,
    input  logic [wb_pkg::esubcode_w-1:0] wb_esubcode,
    input  logic [wb_pkg::xlen-1:0]       wb_pc,
    output logic [wb_pkg::xlen-1:0]       csr_rvalue,
    output logic [wb_pkg::xlen-1:0]       flush_target
);
    import wb_pkg::*;

    logic [1:0]            crmd_plv;
    logic                  crmd_ie;
    logic                  crmd_da;
    logic [1:0]            prmd_pplv;
    logic                  prmd_pie;
    logic [1:0]            estat_is;
    logic [ecode_w-1:0]    estat_ecode;
    logic [esubcode_w-1:0] estat_esubcode;
    logic [xlen-1:0]       era;
    logic [xlen-7:0]       eentry_va;
    logic [xlen-1:0]       save [0:3];

    logic [xlen-1:0] crmd_rv;
    logic [xlen-1:0] prmd_rv;
    logic [xlen-1:0] estat_rv;
    logic [xlen-1:0] eentry_rv;
    logic [xlen-1:0] wmerged;

    // full register views, unimplemented bits read as zero
    always_comb begin
        crmd_rv = '0;
        crmd_rv[crmd_plv_lsb +: 2] = crmd_plv;
        crmd_rv[crmd_ie_bit] = crmd_ie;
        crmd_rv[crmd_da_bit] = crmd_da;

        prmd_rv = '0;
        prmd_rv[prmd_pplv_lsb +: 2] = prmd_pplv;
        prmd_rv[prmd_pie_bit] = prmd_pie;

        estat_rv = '0;
        estat_rv[1:0] = estat_is;
        estat_rv[estat_ecode_lsb +: ecode_w] = estat_ecode;
        estat_rv[estat_esubcode_lsb +: esubcode_w] = estat_esubcode;

        // entry is 64-byte aligned
        eentry_rv = {eentry_va, 6'b000000};
    end

    always_comb begin
        case (csr_num)
            csr_crmd:   csr_rvalue = crmd_rv;
            csr_prmd:   csr_rvalue = prmd_rv;
            csr_estat:  csr_rvalue = estat_rv;
            csr_era:    csr_rvalue = era;
            csr_eentry: csr_rvalue = eentry_rv;
            csr_save0:  csr_rvalue = save[0];
            csr_save1:  csr_rvalue = save[1];
            csr_save2:  csr_rvalue = save[2];
            csr_save3:  csr_rvalue = save[3];
            default:    csr_rvalue = '0;
        endcase
    end

    // old value with the masked bits replaced
    assign wmerged = (csr_rvalue & ~csr_wmask) | (csr_wvalue & csr_wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv       <= 2'b00;
            crmd_ie        <= 1'b0;
            crmd_da        <= 1'b1;
            prmd_pplv      <= 2'b00;
            prmd_pie       <= 1'b0;
            estat_is       <= 2'b00;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            eentry_va      <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else if (wb_ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'b00;
            crmd_ie        <= 1'b0;
            era            <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we) begin
            case (csr_num)
                csr_crmd: begin
                    crmd_plv <= wmerged[crmd_plv_lsb +: 2];
                    crmd_ie  <= wmerged[crmd_ie_bit];
                    crmd_da  <= wmerged[crmd_da_bit];
                end
                csr_prmd: begin
                    prmd_pplv <= wmerged[prmd_pplv_lsb +: 2];
                    prmd_pie  <= wmerged[prmd_pie_bit];
                end
                // only the software interrupt bits are writable
                csr_estat:  estat_is  <= wmerged[1:0];
                csr_era:    era       <= wmerged;
                csr_eentry: eentry_va <= wmerged[xlen-1:6];
                csr_save0:  save[0]   <= wmerged;
                csr_save1:  save[1]   <= wmerged;
                csr_save2:  save[2]   <= wmerged;
                csr_save3:  save[3]   <= wmerged;
                default: begin
                end
            endcase
        end
    end

    assign flush_target = wb_ex ? eentry_rv : era;

endmodule

//--- src/mem_load_align.sv
module mem_load_align (
    input  logic                    is_load,
    input  wb_pkg::ld_op_t          load_op,
    input  logic [1:0]              addr_low,
    input  logic [wb_pkg::xlen-1:0] rdata,
    input  logic [wb_pkg::xlen-1:0] alu_result,
    output logic [wb_pkg::xlen-1:0] rf_result
);
    import wb_pkg::*;

    logic [xlen-1:0] shifted;
    logic [xlen-1:0] load_val;

    // byte lane of the addressed data moved down to bit 0
    assign shifted = rdata >> {addr_low, 3'b000};

    always_comb begin
        load_val = rdata;
        case (load_op)
            ld_b: begin
                load_val = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            end
            ld_bu: begin
                load_val = {{(xlen-8){1'b0}}, shifted[7:0]};
            end
            ld_h: begin
                load_val = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            end
            ld_hu: begin
                load_val = {{(xlen-16){1'b0}}, shifted[15:0]};
            end
            default: begin
                // word loads are aligned, take all of it
                load_val = rdata;
            end
        endcase
    end

    assign rf_result = is_load ? load_val : alu_result;

endmodule

//--- src/regfile.sv
module regfile (
    input  logic                          clk,
    input  logic                          we,
    input  logic [wb_pkg::reg_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr1,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr2,
    output logic [wb_pkg::xlen-1:0]       rdata1,
    output logic [wb_pkg::xlen-1:0]       rdata2
);
    import wb_pkg::*;

    logic [xlen-1:0] rf [0:(1<<reg_addr_w)-1];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // no bypass, a same-cycle write shows up next cycle
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- src/wb_pkg.sv
package wb_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

    // csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;

    // crmd fields
    localparam int crmd_plv_lsb = 0;
    localparam int crmd_ie_bit  = 2;
    localparam int crmd_da_bit  = 3;

    // prmd fields
    localparam int prmd_pplv_lsb = 0;
    localparam int prmd_pie_bit  = 2;

    // estat fields
    localparam int estat_ecode_lsb    = 16;
    localparam int estat_esubcode_lsb = 22;

    // load operations from the memory stage
    typedef enum logic [2:0] {
        ld_w  = 3'd0,
        ld_b  = 3'd1,
        ld_bu = 3'd2,
        ld_h  = 3'd3,
        ld_hu = 3'd4
    } ld_op_t;

endpackage

//--- src/wb_stage.sv
module wb_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          mem_valid,
    input  logic [wb_pkg::xlen-1:0]       mem_pc,
    input  logic                          mem_rf_we,
    input  logic [wb_pkg::reg_addr_w-1:0] mem_rf_waddr,
    input  logic [wb_pkg::xlen-1:0]       mem_rf_result,
    input  logic                          mem_res_from_csr,
    input  logic [wb_pkg::csr_num_w-1:0]  mem_csr_num,
    input  logic                          mem_csr_we,
    input  logic [wb_pkg::xlen-1:0]       mem_csr_wmask,
    input  logic [wb_pkg::xlen-1:0]       mem_csr_wvalue,
    input  logic                          mem_ertn,
    input  logic                          mem_ex,
    input  logic [wb_pkg::ecode_w-1:0]    mem_ecode,
    input  logic [wb_pkg::esubcode_w-1:0] mem_esubcode,
    output logic                          wb_allowin,
    output logic                          rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [wb_pkg::xlen-1:0]       rf_wdata,
    output logic [wb_pkg::xlen-1:0]       wb_pc,
    output logic                          wb_flush,
    output logic [wb_pkg::xlen-1:0]       flush_target
);
    import wb_pkg::*;

    logic                  wb_valid;
    logic                  wb_ready_go;
    logic                  rf_we_r;
    logic [xlen-1:0]       rf_result_r;
    logic                  res_from_csr_r;
    logic [csr_num_w-1:0]  csr_num_r;
    logic                  csr_we_r;
    logic [xlen-1:0]       csr_wmask_r;
    logic [xlen-1:0]       csr_wvalue_r;
    logic                  ertn_r;
    logic                  ex_r;
    logic [ecode_w-1:0]    ecode_r;
    logic [esubcode_w-1:0] esubcode_r;
    logic                  ertn_valid;
    logic                  ex_valid;
    logic                  csr_we_valid;
    logic [xlen-1:0]       csr_rvalue;

    // last stage never stalls
    assign wb_ready_go = 1'b1;
    assign wb_allowin  = !wb_valid || wb_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allowin) begin
            wb_pc          <= mem_pc;
            rf_we_r        <= mem_rf_we;
            rf_waddr       <= mem_rf_waddr;
            rf_result_r    <= mem_rf_result;
            res_from_csr_r <= mem_res_from_csr;
            csr_num_r      <= mem_csr_num;
            csr_we_r       <= mem_csr_we;
            csr_wmask_r    <= mem_csr_wmask;
            csr_wvalue_r   <= mem_csr_wvalue;
            ertn_r         <= mem_ertn;
            ex_r           <= mem_ex;
            ecode_r        <= mem_ecode;
            esubcode_r     <= mem_esubcode;
        end
    end

    assign ertn_valid   = wb_valid && ertn_r;
    assign ex_valid     = wb_valid && ex_r;
    // an excepting instruction must not change csr state
    assign csr_we_valid = wb_valid && csr_we_r && !ex_r;

    csr csr_inst (
        .clk          (clk),
        .resetn       (resetn),
        .csr_num      (csr_num_r),
        .csr_we       (csr_we_valid),
        .csr_wmask    (csr_wmask_r),
        .csr_wvalue   (csr_wvalue_r),
        .ertn_flush   (ertn_valid),
        .wb_ex        (ex_valid),
        .wb_ecode     (ecode_r),
        .wb_esubcode  (esubcode_r),
        .wb_pc        (wb_pc),
        .csr_rvalue   (csr_rvalue),
        .flush_target (flush_target)
    );

    assign rf_we    = wb_valid && rf_we_r;
    assign rf_wdata = res_from_csr_r ? csr_rvalue : rf_result_r;
    assign wb_flush = ertn_valid || ex_valid;

endmodule

//--- src/wb_top.sv
module wb_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          mem_valid,
    input  logic [wb_pkg::xlen-1:0]       mem_pc,
    input  logic                          mem_rf_we,
    input  logic [wb_pkg::reg_addr_w-1:0] mem_rf_waddr,
    input  logic [wb_pkg::xlen-1:0]       mem_alu_result,
    input  logic                          mem_is_load,
    input  wb_pkg::ld_op_t                mem_load_op,
    input  logic [wb_pkg::xlen-1:0]       mem_rdata,
    input  logic                          mem_res_from_csr,
    input  logic [wb_pkg::csr_num_w-1:0]  mem_csr_num,
    input  logic                          mem_csr_we,
    input  logic [wb_pkg::xlen-1:0]       mem_csr_wmask,
    input  logic [wb_pkg::xlen-1:0]       mem_csr_wvalue,
    input  logic                          mem_ertn,
    input  logic                          mem_ex,
    input  logic [wb_pkg::ecode_w-1:0]    mem_ecode,
    input  logic [wb_pkg::esubcode_w-1:0] mem_esubcode,
    input  logic [wb_pkg::reg_addr_w-1:0] rf_raddr1,
    input  logic [wb_pkg::reg_addr_w-1:0] rf_raddr2,
    output logic                          wb_allowin,
    output logic [wb_pkg::xlen-1:0]       rf_rdata1,
    output logic [wb_pkg::xlen-1:0]       rf_rdata2,
    output logic [wb_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [wb_pkg::xlen-1:0]       debug_wb_rf_wdata,
    output logic                          wb_flush,
    output logic [wb_pkg::xlen-1:0]       flush_target
);
    import wb_pkg::*;

    logic [xlen-1:0]       mem_rf_result;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    // tail of the memory stage
    mem_load_align mem_load_align_inst (
        .is_load    (mem_is_load),
        .load_op    (mem_load_op),
        .addr_low   (mem_alu_result[1:0]),
        .rdata      (mem_rdata),
        .alu_result (mem_alu_result),
        .rf_result  (mem_rf_result)
    );

    wb_stage wb_stage_inst (
        .clk              (clk),
        .resetn           (resetn),
        .mem_valid        (mem_valid),
        .mem_pc           (mem_pc),
        .mem_rf_we        (mem_rf_we),
        .mem_rf_waddr     (mem_rf_waddr),
        .mem_rf_result    (mem_rf_result),
        .mem_res_from_csr (mem_res_from_csr),
        .mem_csr_num      (mem_csr_num),
        .mem_csr_we       (mem_csr_we),
        .mem_csr_wmask    (mem_csr_wmask),
        .mem_csr_wvalue   (mem_csr_wvalue),
        .mem_ertn         (mem_ertn),
        .mem_ex           (mem_ex),
        .mem_ecode        (mem_ecode),
        .mem_esubcode     (mem_esubcode),
        .wb_allowin       (wb_allowin),
        .rf_we            (rf_we),
        .rf_waddr         (rf_waddr),
        .rf_wdata         (rf_wdata),
        .wb_pc            (debug_wb_pc),
        .wb_flush         (wb_flush),
        .flush_target     (flush_target)
    );

    regfile regfile_inst (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // trace port wants a byte-enable style strobe
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule
